//--- sources.f
+incdir+verification
source/aud_pkg.sv
source/mem_pkg.sv
source/aud_recorder.sv
source/rec_control.sv
source/sram_writer.sv
source/aud_rec_top.sv
verification/tb_aud_rec_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
TOP      = tb_aud_rec_top
FILELIST = sources.f

SOURCES  = $(shell grep -v '^+' $(FILELIST)) verification/tb_tasks.svh
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// 16-bit Galois LFSR, right shifting with taps 16, 14, 13 and 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

task automatic next_cycle();
    @(posedge i_clk);
    #2;
endtask

// One codec frame: LRC high for 2 cycles, then 16 data bits MSB first and 2 idle low cycles
task automatic send_frame();
    logic [AUD_SAMPLE_W-1:0] sample;
    sample = '0;
    for (int b = 0; b < AUD_SAMPLE_W; b++) begin
        lfsr_state = lfsr_next(lfsr_state);
        sample = {sample[AUD_SAMPLE_W-2:0], lfsr_state[0]};
    end
    if (rec_on && (pushed < MAX_WORDS)) begin
        exp_samples.push_back(sample);  // Only frames the recorder should keep
        pushed++;
    end
    for (int c = 0; c < FRAME_CYCLES; c++) begin
        next_cycle();
        i_lrc  = (c < 2);
        i_data = ((c >= 2) && (c < 18)) ? sample[17-c] : 1'b0;
    end
endtask

// Keys only move while LRC is high
task automatic press_key(input logic stop_key);
    next_cycle();
    i_lrc  = 1'b1;
    i_data = 1'b0;
    if (stop_key) begin
        i_key_stop = 1'b1;
    end else begin
        i_key_rec = 1'b1;
    end
    repeat (3) next_cycle();
    i_key_rec  = 1'b0;
    i_key_stop = 1'b0;
    repeat (3) next_cycle();
endtask

`endif

//--- verification/tb_aud_rec_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_aud_rec_top
    import aud_pkg::*, mem_pkg::*;
;

    localparam int MAX_WORDS       = 40;
    localparam int SAMPLE_RATE     = 8;
    localparam int FRAME_CYCLES    = 20;
    localparam int NUM_FRAMES      = 52;
    localparam int WATCHDOG_CYCLES = (NUM_FRAMES + 10) * FRAME_CYCLES;

    logic                    i_clk;
    logic                    i_rst_n;
    logic                    i_lrc;
    logic                    i_data;
    logic                    i_key_rec;
    logic                    i_key_stop;
    logic [MEM_ADDR_W-1:0]   o_sram_addr;
    logic [MEM_DATA_W-1:0]   o_sram_dq;
    logic                    o_sram_we_n;
    logic                    o_sram_ce_n;
    logic                    o_recording;
    logic                    o_paused;
    logic                    o_done;
    logic [AUD_SEC_W-1:0]    o_seconds;

    logic [AUD_SAMPLE_W-1:0] exp_samples[$];  // Reference model of samples still to be written
    logic [AUD_SAMPLE_W-1:0] exp_data;
    logic [15:0]             lfsr_state;
    logic                    rec_on;
    logic                    we_prev;
    logic                    done_prev;
    int                      pushed;
    int                      exp_addr;
    int                      done_count;
    int                      checks;
    int                      errors;
    string                   test_name;

    `include "tb_tasks.svh"

    aud_rec_top #(
        .P_MAX_WORDS   (MAX_WORDS),
        .P_SAMPLE_RATE (SAMPLE_RATE)
    ) aud_rec_top_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_lrc       (i_lrc),
        .i_data      (i_data),
        .i_key_rec   (i_key_rec),
        .i_key_stop  (i_key_stop),
        .o_sram_addr (o_sram_addr),
        .o_sram_dq   (o_sram_dq),
        .o_sram_we_n (o_sram_we_n),
        .o_sram_ce_n (o_sram_ce_n),
        .o_recording (o_recording),
        .o_paused    (o_paused),
        .o_done      (o_done),
        .o_seconds   (o_seconds)
    );

    task automatic expect_equal(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("error %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("%s: %s", test_name, msg);
        end
    endtask

    task automatic start_recording();
        exp_addr = 0;
        pushed   = 0;
        press_key(1'b0);
        rec_on = 1'b1;
    endtask

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Outputs are sampled on the falling edge, halfway between register updates
    always @(negedge i_clk) begin
        if (i_rst_n == 1'b0) begin
            if (we_prev && !o_sram_we_n) begin
                expect_true(exp_samples.size() > 0,
                            "SRAM write happened with no sample expected");
                expect_equal("o_sram_ce_n", 0, o_sram_ce_n);
                if (exp_samples.size() > 0) begin
                    exp_data = exp_samples.pop_front();
                    expect_equal("o_sram_dq", exp_data, o_sram_dq);
                    expect_equal("o_sram_addr", exp_addr, o_sram_addr);
                end
                exp_addr++;
            end
            if (!we_prev && o_sram_we_n) begin
                expect_equal("o_seconds", exp_addr / SAMPLE_RATE, o_seconds);
                expect_equal("o_sram_ce_n", 0, o_sram_ce_n);  // Chip stays selected for the hold cycle
            end
            expect_true(!(o_done && done_prev), "o_done stayed high for more than one cycle");
            if (o_done) begin
                done_count++;
            end
        end
        we_prev   = o_sram_we_n;
        done_prev = o_done;
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("Watchdog expired before the test sequence finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        i_rst_n    = 1'b1;  // Reset is active high
        i_lrc      = 1'b0;
        i_data     = 1'b0;
        i_key_rec  = 1'b0;
        i_key_stop = 1'b0;
        lfsr_state = 16'd30790;
        rec_on     = 1'b0;
        we_prev    = 1'b1;
        done_prev  = 1'b0;
        pushed     = 0;
        exp_addr   = 0;
        done_count = 0;
        checks     = 0;
        errors     = 0;
        test_name  = "reset";
        repeat (2) next_cycle();
        i_rst_n = 1'b0;
        next_cycle();
        expect_equal("o_sram_we_n", 1, o_sram_we_n);
        expect_equal("o_sram_ce_n", 1, o_sram_ce_n);
        expect_equal("o_recording", 0, o_recording);
        expect_equal("o_paused", 0, o_paused);
        expect_equal("o_done", 0, o_done);
        expect_equal("o_seconds", 0, o_seconds);

        test_name = "capture";
        start_recording();
        expect_equal("o_recording", 1, o_recording);
        repeat (5) send_frame();

        test_name = "pause";
        rec_on = 1'b0;
        press_key(1'b0);
        expect_equal("o_paused", 1, o_paused);
        repeat (2) send_frame();
        press_key(1'b0);
        rec_on = 1'b1;
        expect_equal("o_recording", 1, o_recording);
        repeat (3) send_frame();

        test_name = "stop";
        rec_on = 1'b0;
        press_key(1'b1);
        expect_equal("o_done pulses", 1, done_count);
        expect_equal("o_recording", 0, o_recording);
        send_frame();  // Recorder is idle, so this frame must not be written

        test_name = "memory full";
        start_recording();
        repeat (MAX_WORDS + 1) send_frame();
        repeat (4) next_cycle();  // A write of the last frame would show up here
        expect_equal("o_done pulses", 2, done_count);
        expect_equal("o_recording", 0, o_recording);
        expect_equal("writes", MAX_WORDS, exp_addr);
        expect_equal("pending samples", 0, exp_samples.size());

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/aud_rec_top.sv
`timescale 1ns/100ps
`default_nettype none

module aud_rec_top
    import aud_pkg::*, mem_pkg::*;
#(
    parameter int P_MAX_WORDS   = AUD_MAX_WORDS,
    parameter int P_SAMPLE_RATE = AUD_SAMPLE_RATE
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_lrc,
    input  logic                  i_data,
    input  logic                  i_key_rec,
    input  logic                  i_key_stop,
    output logic [MEM_ADDR_W-1:0] o_sram_addr,
    output logic [MEM_DATA_W-1:0] o_sram_dq,
    output logic                  o_sram_we_n,
    output logic                  o_sram_ce_n,
    output logic                  o_recording,
    output logic                  o_paused,
    output logic                  o_done,
    output logic [AUD_SEC_W-1:0]  o_seconds
);

    logic                    start_pulse, pause_pulse, stop_pulse;
    logic                    busy;
    logic                    sample_valid;
    logic [AUD_SAMPLE_W-1:0] sample_data;
    logic [MEM_ADDR_W-1:0]   sample_addr;

    assign o_recording = busy & ~o_paused;

    rec_control #(.P_SAMPLE_RATE(P_SAMPLE_RATE)) rec_control_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_key_rec      (i_key_rec),
        .i_key_stop     (i_key_stop),
        .i_busy         (busy),
        .i_sample_valid (sample_valid),
        .o_start        (start_pulse),
        .o_pause        (pause_pulse),
        .o_stop         (stop_pulse),
        .o_seconds      (o_seconds)
    );

    aud_recorder #(.P_MAX_WORDS(P_MAX_WORDS)) aud_recorder_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_lrc          (i_lrc),
        .i_data         (i_data),
        .i_start        (start_pulse),
        .i_pause        (pause_pulse),
        .i_stop         (stop_pulse),
        .o_address      (sample_addr),
        .o_data         (sample_data),
        .o_sample_valid (sample_valid),
        .o_busy         (busy),
        .o_paused       (o_paused),
        .o_done         (o_done)
    );

    sram_writer sram_writer_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (sample_valid),
        .i_addr      (sample_addr),
        .i_data      (sample_data),
        .o_sram_addr (o_sram_addr),
        .o_sram_dq   (o_sram_dq),
        .o_sram_we_n (o_sram_we_n),
        .o_sram_ce_n (o_sram_ce_n)
    );

endmodule

`default_nettype wire

//--- source/sram_writer.sv
`timescale 1ns/100ps
`default_nettype none

module sram_writer
    import mem_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    input  logic [MEM_ADDR_W-1:0] i_addr,
    input  logic [MEM_DATA_W-1:0] i_data,
    output logic [MEM_ADDR_W-1:0] o_sram_addr,
    output logic [MEM_DATA_W-1:0] o_sram_dq,
    output logic                  o_sram_we_n,
    output logic                  o_sram_ce_n
);

    localparam int CNT_W = $clog2(MEM_WE_CYCLES + 2);
    localparam logic [CNT_W-1:0] CNT_START = CNT_W'(MEM_WE_CYCLES + 1);  // Extra hold cycle

    logic [CNT_W-1:0]      cnt_r, cnt_w;
    logic [MEM_ADDR_W-1:0] addr_r;
    logic [MEM_DATA_W-1:0] data_r;
    logic                  we_n_r, ce_n_r;

    assign o_sram_addr = addr_r;
    assign o_sram_dq   = data_r;
    assign o_sram_we_n = we_n_r;
    assign o_sram_ce_n = ce_n_r;

    always_comb begin
        if (i_valid) begin
            cnt_w = CNT_START;
        end else if (cnt_r != '0) begin
            cnt_w = cnt_r - 1'b1;
        end else begin
            cnt_w = cnt_r;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            cnt_r  <= '0;
            we_n_r <= 1'b1;
            ce_n_r <= 1'b1;
        end else begin
            cnt_r  <= cnt_w;
            we_n_r <= (cnt_w <= 1);  // Last count keeps the bus stable after the write edge
            ce_n_r <= (cnt_w == '0);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            addr_r <= i_addr;
            data_r <= i_data;
        end
    end

    a_no_overlapping_write: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_valid |-> (cnt_r == '0));

endmodule

`default_nettype wire

//--- source/rec_control.sv
`timescale 1ns/100ps
`default_nettype none

module rec_control
    import aud_pkg::*;
#(
    parameter int P_SAMPLE_RATE = AUD_SAMPLE_RATE
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_key_rec,
    input  logic                 i_key_stop,
    input  logic                 i_busy,
    input  logic                 i_sample_valid,
    output logic                 o_start,
    output logic                 o_pause,
    output logic                 o_stop,
    output logic [AUD_SEC_W-1:0] o_seconds
);

    localparam int CNT_W = $clog2(P_SAMPLE_RATE + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(P_SAMPLE_RATE - 1);

    logic                 key_rec_q, key_rec_d;
    logic                 key_stop_q, key_stop_d;
    logic                 rec_edge, stop_edge;
    logic                 start_r, pause_r, stop_r;
    logic [CNT_W-1:0]     sample_cnt_r;
    logic [AUD_SEC_W-1:0] seconds_r;
    logic                 second_done;

    assign rec_edge    = key_rec_q & ~key_rec_d;
    assign stop_edge   = key_stop_q & ~key_stop_d;
    assign second_done = i_sample_valid && (sample_cnt_r == CNT_LAST);

    assign o_start   = start_r;
    assign o_pause   = pause_r;
    assign o_stop    = stop_r;
    assign o_seconds = seconds_r;

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            key_rec_q  <= 1'b0;
            key_rec_d  <= 1'b0;
            key_stop_q <= 1'b0;
            key_stop_d <= 1'b0;
            start_r    <= 1'b0;
            pause_r    <= 1'b0;
            stop_r     <= 1'b0;
        end else begin
            key_rec_q  <= i_key_rec;
            key_rec_d  <= key_rec_q;
            key_stop_q <= i_key_stop;
            key_stop_d <= key_stop_q;
            stop_r     <= stop_edge;
            start_r    <= rec_edge & ~stop_edge & ~i_busy;  // Stop wins over a record press
            pause_r    <= rec_edge & ~stop_edge & i_busy;  // Same key toggles pause and resume
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            sample_cnt_r <= '0;
            seconds_r    <= '0;
        end else if (start_r) begin
            sample_cnt_r <= '0;
            seconds_r    <= '0;
        end else if (second_done) begin
            sample_cnt_r <= '0;
            seconds_r    <= seconds_r + 1'b1;
        end else if (i_sample_valid) begin
            sample_cnt_r <= sample_cnt_r + 1'b1;
        end
    end

    a_one_control_pulse: assert property (@(posedge i_clk) disable iff (i_rst_n)
        $onehot0({o_start, o_pause, o_stop}));

endmodule

`default_nettype wire

//--- source/aud_recorder.sv
`timescale 1ns/100ps
`default_nettype none

module aud_recorder
    import aud_pkg::*, mem_pkg::*;
#(
    parameter int P_MAX_WORDS = AUD_MAX_WORDS
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_lrc,
    input  logic                    i_data,
    input  logic                    i_start,
    input  logic                    i_pause,
    input  logic                    i_stop,
    output logic [MEM_ADDR_W-1:0]   o_address,
    output logic [AUD_SAMPLE_W-1:0] o_data,
    output logic                    o_sample_valid,
    output logic                    o_busy,
    output logic                    o_paused,
    output logic                    o_done
);

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_WAIT_HIGH = 3'd1;
    localparam logic [2:0] S_WAIT_LOW  = 3'd2;
    localparam logic [2:0] S_REC       = 3'd3;
    localparam logic [2:0] S_PAUSE     = 3'd4;
    localparam logic [2:0] S_FINISH    = 3'd5;

    logic [2:0]                         state_r, state_w;
    logic [MEM_ADDR_W-1:0]              address_r, address_w;
    logic [AUD_SAMPLE_W-1:0]            data_r, data_w;
    logic [$clog2(AUD_SAMPLE_W + 1)-1:0] count_r, count_w;
    logic                               valid_r, valid_w;
    logic                               mem_full;

    assign mem_full       = (address_r == MEM_ADDR_W'(P_MAX_WORDS));
    assign o_address      = address_r;
    assign o_data         = data_r;
    assign o_sample_valid = valid_r;
    assign o_busy         = (state_r != S_IDLE) && (state_r != S_FINISH);
    assign o_paused       = (state_r == S_PAUSE);
    assign o_done         = (state_r == S_FINISH);  // Finish lasts exactly one cycle

    always_comb begin
        state_w   = state_r;
        address_w = valid_r ? address_r + 1'b1 : address_r;  // Step after the sample is handed over
        data_w    = data_r;
        count_w   = count_r;
        valid_w   = 1'b0;
        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    state_w   = S_WAIT_HIGH;
                    address_w = '0;
                    count_w   = '0;
                end
            end
            S_WAIT_HIGH: begin
                if (i_stop || mem_full) begin
                    state_w = S_FINISH;
                end else if (i_pause) begin
                    state_w = S_PAUSE;
                end else if (i_lrc) begin
                    state_w = S_WAIT_LOW;
                end
            end
            S_WAIT_LOW: begin
                if (i_stop || mem_full) begin
                    state_w = S_FINISH;
                end else if (i_pause) begin
                    state_w = S_PAUSE;
                end else if (!i_lrc) begin
                    data_w  = {data_r[AUD_SAMPLE_W-2:0], i_data};  // MSB arrives with the falling LRC
                    count_w = 1'b1;
                    state_w = S_REC;
                end
            end
            S_REC: begin
                if (i_stop) begin
                    state_w = S_FINISH;
                end else if (i_pause) begin
                    state_w = S_PAUSE;
                end else if (count_r == AUD_SAMPLE_W) begin
                    valid_w = 1'b1;
                    count_w = '0;
                    state_w = S_WAIT_HIGH;
                end else begin
                    data_w  = {data_r[AUD_SAMPLE_W-2:0], i_data};
                    count_w = count_r + 1'b1;
                end
            end
            S_PAUSE: begin
                // A sample cut in half resumes on the bits that follow
                if (i_stop) begin
                    state_w = S_FINISH;
                end else if (i_pause) begin
                    state_w = (count_r == '0) ? S_WAIT_HIGH : S_REC;
                end
            end
            S_FINISH: begin
                state_w = S_IDLE;
            end
            default: begin
                state_w = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r   <= S_IDLE;
            address_r <= '0;
            count_r   <= '0;
            valid_r   <= 1'b0;
        end else begin
            state_r   <= state_w;
            address_r <= address_w;
            count_r   <= count_w;
            valid_r   <= valid_w;
        end
    end

    always_ff @(posedge i_clk) begin
        data_r <= data_w;
    end

    a_valid_while_recording: assert property (@(posedge i_clk) disable iff (i_rst_n)
        o_sample_valid |-> o_busy && !o_paused && (o_address < MEM_ADDR_W'(P_MAX_WORDS)));

    a_address_in_range: assert property (@(posedge i_clk) disable iff (i_rst_n)
        o_address <= MEM_ADDR_W'(P_MAX_WORDS));

endmodule

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int MEM_ADDR_W = 20;  // Word address into the external SRAM
    localparam int MEM_DATA_W = 16;  // One sample per SRAM word

    localparam int MEM_WE_CYCLES = 2;  // Write enable low time in clock cycles

endpackage

`default_nettype wire

//--- source/aud_pkg.sv
`default_nettype none

package aud_pkg;

    // Codec word size, only the left channel is kept
    localparam int AUD_SAMPLE_W = 16;

    localparam int AUD_SAMPLE_RATE = 32000;  // Samples per second on the left channel

    // A full recording of 32 seconds at the default rate
    localparam int AUD_MAX_WORDS = 1024000;

    localparam int AUD_SEC_W = 6;  // Seconds display width

endpackage

`default_nettype wire
